// File: common/icache_settings.svh
`ifndef ICACHE_SETTINGS_SVH
`define ICACHE_SETTINGS_SVH

// geometry of the instruction cache

// byte address width seen by core and memory
`define ICACHE_ADDR_W 32

// sets per way, one tag and one line per set
`define ICACHE_SETS 64

// associativity
`define ICACHE_WAYS 2

// 32-bit words per line, so a 16-byte line
`define ICACHE_LINE_WORDS 4

`endif

// File: common/icache_pkg.sv
`default_nettype none

`include "icache_settings.svh"

package icache_pkg;

    // instruction word and byte offset inside it
    localparam int word_w = 32;
    localparam int byte_off_w = 2;

    // address field widths, low to high
    localparam int word_off_w = $clog2(`ICACHE_LINE_WORDS);
    localparam int line_off_w = word_off_w + byte_off_w;
    localparam int set_w = $clog2(`ICACHE_SETS);
    localparam int tag_w = `ICACHE_ADDR_W - set_w - line_off_w;

    // byte address, bits 1..0 taken as zero
    typedef logic [`ICACHE_ADDR_W-1:0] addr_t;
    typedef logic [word_w-1:0] word_t;

    // word 0 sits in the low bits of a line
    typedef logic [`ICACHE_LINE_WORDS*word_w-1:0] line_t;

    // address bits 9..4
    typedef logic [set_w-1:0] set_idx_t;
    // address bits 31..10
    typedef logic [tag_w-1:0] tag_t;
    // address bits 3..2
    typedef logic [word_off_w-1:0] word_off_t;

    // one bit per way, used for hits and for the fill victim
    typedef logic [`ICACHE_WAYS-1:0] way_mask_t;

endpackage

`default_nettype wire

// File: src/way_store.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

// single-port storage for one way of the cache
// one entry per set, registered read
// the same module holds tags and lines, picked by entry_t
module way_store #(
    parameter type entry_t = icache_pkg::tag_t,
    parameter int depth = `ICACHE_SETS
) (
    input wire clk,
    // access enable, read when we is low
    input wire en,
    input wire we,
    input wire icache_pkg::set_idx_t idx,
    input wire entry_t wdata,
    // holds the last read until the next read
    output entry_t rdata
);

    // array contents come up unknown
    // valid bits in the cache core keep them from being used
    entry_t mem [depth];

    // write port
    always_ff @(posedge clk) begin
        if (en && we) begin
            mem[idx] <= wdata;
        end
    end

    // read port
    // a write leaves rdata alone so the cache core can still
    // see the tags it read on the miss while it picks a victim
    always_ff @(posedge clk) begin
        if (en && !we) begin
            rdata <= mem[idx];
        end
    end

endmodule

`default_nettype wire

// File: cache/cache_core.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

// two-way tag compare, valid bits, victim choice and word select
// lookup result comes one cycle after the lookup strobe
module cache_core (
    input wire clk,
    input wire rst_n,
    input wire lookup,
    input wire icache_pkg::addr_t lookup_adr,
    input wire fill,
    input wire icache_pkg::line_t fill_line,
    output logic hit,
    output logic miss,
    output icache_pkg::word_t hit_word
);

    import icache_pkg::*;

    // fields of the incoming address
    tag_t req_tag;
    set_idx_t req_set;
    word_off_t req_off;

    // fields held from the last lookup
    tag_t tag_q;
    set_idx_t set_q;
    word_off_t off_q;
    logic look_q;

    // per set, one valid bit per way
    way_mask_t valid [`ICACHE_SETS];

    tag_t tag_rd [`ICACHE_WAYS];
    line_t line_rd [`ICACHE_WAYS];
    way_mask_t way_en;
    way_mask_t way_we;
    way_mask_t way_hit;
    way_mask_t fill_match;
    way_mask_t victim;
    line_t hit_line;
    logic [15:0] lfsr;

    assign req_tag = lookup_adr[`ICACHE_ADDR_W-1 -: tag_w];
    assign req_set = lookup_adr[line_off_w +: set_w];
    assign req_off = lookup_adr[byte_off_w +: word_off_w];

    // lookup reads every way, a fill writes only the victim
    assign way_we = fill ? victim : '0;
    assign way_en = {`ICACHE_WAYS{lookup}} | way_we;

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        way_store #(
            .entry_t(tag_t)
        ) i_tag_store (
            .clk(clk),
            .en(way_en[w]),
            .we(way_we[w]),
            .idx(req_set),
            .wdata(req_tag),
            .rdata(tag_rd[w])
        );

        way_store #(
            .entry_t(line_t)
        ) i_data_store (
            .clk(clk),
            .en(way_en[w]),
            .we(way_we[w]),
            .idx(req_set),
            .wdata(fill_line),
            .rdata(line_rd[w])
        );

        // valid gates the compare, never-written tags are unknown
        assign way_hit[w] = valid[set_q][w] && (tag_rd[w] == tag_q);
        // same compare against the fill address, reusing the miss read
        assign fill_match[w] = valid[req_set][w] && (tag_rd[w] == req_tag);
    end

    // hold the address fields for the result cycle
    always_ff @(posedge clk) begin
        if (lookup) begin
            tag_q <= req_tag;
            set_q <= req_set;
            off_q <= req_off;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            look_q <= 1'b0;
        end else begin
            look_q <= lookup;
        end
    end

    // result is only meaningful in the cycle after a lookup
    assign hit = look_q && (|way_hit);
    assign miss = look_q && !(|way_hit);

    // one-hot way select, then word by registered offset
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (way_hit[w]) begin
                hit_line |= line_rd[w];
            end
        end
    end

    assign hit_word = hit_line[off_q*word_w +: word_w];

    // free-running lfsr, taps 16,14,13,11
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lfsr <= 16'hace1;
        end else begin
            lfsr <= {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
        end
    end

    // victim: matching way, then first invalid way, then random
    always_comb begin
        victim = '0;
        if (|fill_match) begin
            victim = fill_match;
        end else if (!valid[req_set][0]) begin
            victim[0] = 1'b1;
        end else if (!valid[req_set][1]) begin
            victim[1] = 1'b1;
        end else begin
            victim[lfsr[0]] = 1'b1;
        end
    end

    // valid bits only ever get set, there is no invalidate
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid[s] <= '0;
            end
        end else if (fill) begin
            valid[req_set] <= valid[req_set] | victim;
        end
    end

    // the fill policy must never leave the same tag in two ways
    a_one_way_hit: assert property (@(posedge clk) disable iff (!rst_n)
        look_q |-> $onehot0(way_hit));

    // a lookup of the line written by the fill just before it must hit
    a_fill_then_hit: assert property (@(posedge clk) disable iff (!rst_n)
        (fill ##1 (lookup && req_set == $past(req_set) && req_tag == $past(req_tag)))
            |=> hit);

endmodule

`default_nettype wire

// File: src/fetch_port.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

// wishbone classic slave facing the core
// every ack is served from a cache hit; a miss refills and looks again
module fetch_port (
    input wire clk,
    input wire rst_n,
    input wire cyc,
    input wire stb,
    input wire we,
    input wire icache_pkg::addr_t adr,
    output icache_pkg::word_t rdata,
    output logic ack,
    output logic err,
    output logic lookup,
    output icache_pkg::addr_t lookup_adr,
    input wire hit,
    input wire miss,
    input wire icache_pkg::word_t hit_word,
    output logic refill_start,
    output icache_pkg::addr_t refill_adr,
    input wire refill_done,
    input wire icache_pkg::line_t refill_line,
    output logic fill,
    output icache_pkg::line_t fill_line
);

    import icache_pkg::*;

    typedef enum logic [2:0] {
        st_idle,
        st_look,
        st_refill,
        st_fill,
        st_relook
    } state_t;

    state_t state;
    addr_t adr_q;
    logic req_new;

    // core keeps cyc/stb up through the ack/err cycle, don't take it twice
    assign req_new = (state == st_idle) && cyc && stb && !ack && !err;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
            ack <= 1'b0;
            err <= 1'b0;
        end else begin
            ack <= 1'b0;
            err <= 1'b0;
            case (state)
                st_idle: begin
                    // writes are refused without touching the cache
                    if (req_new && we) begin
                        err <= 1'b1;
                    end else if (req_new) begin
                        state <= st_look;
                    end
                end
                st_look: begin
                    if (hit) begin
                        ack <= 1'b1;
                        state <= st_idle;
                    end else if (miss) begin
                        state <= st_refill;
                    end
                end
                st_refill: begin
                    if (refill_done) begin
                        state <= st_fill;
                    end
                end
                st_fill: state <= st_relook;
                st_relook: state <= st_look;
                default: state <= st_idle;
            endcase
        end
    end

    // request address and returned word
    always_ff @(posedge clk) begin
        if (req_new) begin
            adr_q <= adr;
        end
        if (state == st_look && hit) begin
            rdata <= hit_word;
        end
    end

    // first lookup goes out in the request cycle, straight from adr
    assign lookup = (req_new && !we) || (state == st_relook);
    assign lookup_adr = (state == st_idle) ? adr : adr_q;

    // refill starts off the miss itself
    assign refill_start = (state == st_look) && miss;
    assign refill_adr = {adr_q[`ICACHE_ADDR_W-1:line_off_w], {line_off_w{1'b0}}};

    // refill master holds its line until the next refill
    assign fill = (state == st_fill);
    assign fill_line = refill_line;

    // completion only inside a live bus cycle
    a_resp_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        (ack || err) |-> (cyc && stb));

    // ack or err lasts a single cycle while the core still holds stb
    a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        (ack || err) |=> !(ack || err));

endmodule

`default_nettype wire

// File: src/refill_master.sv
`timescale 1ns/100ps
`default_nettype none

`include "icache_settings.svh"

// wishbone classic master, reads one line as four single-word beats
// cyc stays up for the whole line, stb is held through each wait
module refill_master (
    input wire clk,
    input wire rst_n,
    input wire refill_start,
    input wire icache_pkg::addr_t refill_adr,
    output logic refill_done,
    output icache_pkg::line_t refill_line,
    output logic m_cyc,
    output logic m_stb,
    output icache_pkg::addr_t m_adr,
    input wire icache_pkg::word_t m_rdata,
    input wire m_ack
);

    import icache_pkg::*;

    // beat counter doubles as the word offset on the bus
    logic active;
    word_off_t beat;
    logic last_beat;

    // line number of the refill, low bits are the beat
    logic [`ICACHE_ADDR_W-1:line_off_w] base;

    assign last_beat = (beat == word_off_t'(`ICACHE_LINE_WORDS - 1));

    // bus cycle control
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active <= 1'b0;
            beat <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= 1'b0;
            if (refill_start) begin
                active <= 1'b1;
                beat <= '0;
            end else if (active && m_ack) begin
                beat <= beat + 1'b1;
                // fourth ack closes the cycle
                if (last_beat) begin
                    active <= 1'b0;
                    refill_done <= 1'b1;
                end
            end
        end
    end

    // line base and assembled data
    always_ff @(posedge clk) begin
        if (refill_start) begin
            base <= refill_adr[`ICACHE_ADDR_W-1:line_off_w];
        end
        // words shift in from the top, so word 0 ends in the low bits
        if (active && m_ack) begin
            refill_line <= {m_rdata, refill_line[$bits(line_t)-1:word_w]};
        end
    end

    assign m_cyc = active;
    assign m_stb = active;
    // base + 0, 4, 8, 12
    assign m_adr = {base, beat, {byte_off_w{1'b0}}};

    // classic handshake, strobe and address held until ack
    a_hold_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (m_stb && !m_ack) |=> (m_cyc && m_stb && $stable(m_adr)));

    // fetch port never starts a refill over a running one
    a_no_overlap: assert property (@(posedge clk) disable iff (!rst_n)
        refill_start |-> !m_cyc);

endmodule

`default_nettype wire

// File: src/icache_top.sv
`timescale 1ns/100ps
`default_nettype none

// two-way read-only instruction cache
// core side is a wishbone classic slave, memory side a classic master
module icache_top (
    input wire clk,
    input wire rst_n,
    // core fetch port
    input wire cyc,
    input wire stb,
    input wire we,
    input wire icache_pkg::addr_t adr,
    output icache_pkg::word_t rdata,
    output logic ack,
    output logic err,
    // memory port
    output logic m_cyc,
    output logic m_stb,
    output icache_pkg::addr_t m_adr,
    input wire icache_pkg::word_t m_rdata,
    input wire m_ack
);

    import icache_pkg::*;

    // fetch port to cache core
    logic lookup;
    addr_t lookup_adr;
    logic hit;
    logic miss;
    word_t hit_word;
    logic fill;
    line_t fill_line;

    // fetch port to refill master
    logic refill_start;
    addr_t refill_adr;
    logic refill_done;
    line_t refill_line;

    fetch_port i_fetch_port (
        .clk(clk),
        .rst_n(rst_n),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .rdata(rdata),
        .ack(ack),
        .err(err),
        .lookup(lookup),
        .lookup_adr(lookup_adr),
        .hit(hit),
        .miss(miss),
        .hit_word(hit_word),
        .refill_start(refill_start),
        .refill_adr(refill_adr),
        .refill_done(refill_done),
        .refill_line(refill_line),
        .fill(fill),
        .fill_line(fill_line)
    );

    cache_core i_cache_core (
        .clk(clk),
        .rst_n(rst_n),
        .lookup(lookup),
        .lookup_adr(lookup_adr),
        .fill(fill),
        .fill_line(fill_line),
        .hit(hit),
        .miss(miss),
        .hit_word(hit_word)
    );

    refill_master i_refill_master (
        .clk(clk),
        .rst_n(rst_n),
        .refill_start(refill_start),
        .refill_adr(refill_adr),
        .refill_done(refill_done),
        .refill_line(refill_line),
        .m_cyc(m_cyc),
        .m_stb(m_stb),
        .m_adr(m_adr),
        .m_rdata(m_rdata),
        .m_ack(m_ack)
    );

endmodule

`default_nettype wire

// File: bench/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

// wishbone classic memory behind the refill master
// each word is computed from its own address
// every beat waits 0 to 3 cycles before its ack
module mem_model (
    input wire clk,
    input wire cyc,
    input wire stb,
    input wire icache_pkg::addr_t adr,
    output icache_pkg::word_t rdata,
    output logic ack
);

    import icache_pkg::*;

    // wait cycles left for the current beat, -1 while no beat is pending
    int wait_left;

    // contents at a byte address, low two bits taken as zero
    function automatic word_t stored_word(input addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    initial begin
        ack = 1'b0;
        rdata = '0;
        wait_left = -1;
        forever begin
            @(posedge clk);
            // outputs move a little after the edge
            #1;
            // ack is a one-cycle pulse per beat
            ack = 1'b0;
            if (!(cyc && stb)) begin
                wait_left = -1;
            end else if (wait_left < 0) begin
                // new beat on the bus, pick its wait
                wait_left = int'($urandom % 4);
            end
            if (wait_left == 0) begin
                ack = 1'b1;
                rdata = stored_word(adr);
                wait_left = -1;
            end else if (wait_left > 0) begin
                wait_left--;
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/tb_icache.sv
`timescale 1ns/100ps
`default_nettype none

// testbench for the two-way instruction cache
// the concurrent assertions below do the checking
module tb_icache;

    import icache_pkg::*;

    // directed requests, then a random mix over two sets
    localparam int n_directed = 13;
    localparam int n_random = 40;
    localparam int n_req = n_directed + n_random;
    // a miss with slow memory takes about 25 cycles
    localparam int cycle_limit = 40 * n_req;

    logic clk;
    logic rst_n;
    logic cyc;
    logic stb;
    logic we;
    addr_t adr;
    word_t rdata;
    logic ack;
    logic err;
    logic m_cyc;
    logic m_stb;
    addr_t m_adr;
    word_t m_rdata;
    logic m_ack;

    // what the running request has to do
    logic expect_hit;
    logic expect_refill;

    logic rst_q;
    logic saw_refill;
    logic [2:0] beat_cnt;
    int cycle_cnt = 0;
    int data_errs = 0;
    int timing_errs = 0;
    int bus_errs = 0;
    int seed_val;

    // three tags that share set_a
    tag_t tag_a;
    tag_t tag_b;
    tag_t tag_c;
    set_idx_t set_a;
    tag_t r_tag;
    set_idx_t r_set;
    word_off_t r_word;
    logic r_write;

    icache_top i_dut (
        .clk(clk),
        .rst_n(rst_n),
        .cyc(cyc),
        .stb(stb),
        .we(we),
        .adr(adr),
        .rdata(rdata),
        .ack(ack),
        .err(err),
        .m_cyc(m_cyc),
        .m_stb(m_stb),
        .m_adr(m_adr),
        .m_rdata(m_rdata),
        .m_ack(m_ack)
    );

    mem_model i_mem (
        .clk(clk),
        .cyc(m_cyc),
        .stb(m_stb),
        .adr(m_adr),
        .rdata(m_rdata),
        .ack(m_ack)
    );

    // memory contents as the core must see them
    function automatic word_t model_word(input addr_t a);
        return {a[31:2], 2'b00} ^ 32'h5a5a_0000;
    endfunction

    function automatic addr_t line_base(input addr_t a);
        return {a[31:4], 4'b0000};
    endfunction

    function automatic addr_t word_adr(input tag_t t, input set_idx_t s, input word_off_t w);
        return {t, s, w, 2'b00};
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // high from the second edge after reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_q <= 1'b0;
        end else begin
            rst_q <= 1'b1;
        end
    end

    // any memory cycle inside the current core request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            saw_refill <= 1'b0;
        end else if (!stb) begin
            saw_refill <= 1'b0;
        end else if (m_cyc) begin
            saw_refill <= 1'b1;
        end
    end

    // acked beats in the current memory cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_cnt <= '0;
        end else if (!m_cyc) begin
            beat_cnt <= '0;
        end else if (m_ack) begin
            beat_cnt <= beat_cnt + 3'd1;
        end
    end

    // quiet bus during reset and the cycle after
    a_reset_quiet: assert property (@(posedge clk)
        (!rst_n || !rst_q) |-> (!ack && !err && !m_cyc))
        else begin
            bus_errs++;
            $display("ack, err or m_cyc was high during reset or just after it");
        end

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        ack |-> (rdata == model_word(adr)))
        else begin
            data_errs++;
            $display("error rdata expected %08h actual %08h",
                model_word($sampled(adr)), $sampled(rdata));
        end

    // reads end with ack, writes with err
    a_resp_kind: assert property (@(posedge clk) disable iff (!rst_n)
        (ack || err) |-> (err == we))
        else begin
            bus_errs++;
            $display("response did not match the cycle type");
        end

    a_hit_timing: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(stb) && expect_hit) |-> (!ack && !m_cyc) ##1 (!ack && !m_cyc)
            ##1 (ack && !m_cyc))
        else begin
            timing_errs++;
            $display("read of a cached line did not ack two cycles after the request");
        end

    a_write_err: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(stb) && we) |-> (!ack && !err && !m_cyc) ##1 (err && !ack && !m_cyc))
        else begin
            bus_errs++;
            $display("write cycle did not end with err alone one cycle later");
        end

    a_refill_seen: assert property (@(posedge clk) disable iff (!rst_n)
        (ack && expect_refill) |-> saw_refill)
        else begin
            timing_errs++;
            $display("read that had to miss finished without a refill");
        end

    // beats walk the line base plus 0, 4, 8, 12
    a_beat_adr: assert property (@(posedge clk) disable iff (!rst_n)
        m_cyc |-> (m_adr == line_base(adr) + (addr_t'(beat_cnt) << 2)))
        else begin
            bus_errs++;
            $display("error m_adr expected %08h actual %08h",
                line_base($sampled(adr)) + (addr_t'($sampled(beat_cnt)) << 2),
                $sampled(m_adr));
        end

    // strobe only inside a memory cycle
    a_stb_in_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        m_stb |-> m_cyc)
        else begin
            bus_errs++;
            $display("m_stb was high outside an m_cyc period");
        end

    // a beat keeps strobe and address until memory acks it
    a_beat_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (m_stb && !m_ack) |=> (m_cyc && m_stb && $stable(m_adr)))
        else begin
            bus_errs++;
            $display("m_stb or m_adr changed before the beat was acked");
        end

    a_beat_limit: assert property (@(posedge clk) disable iff (!rst_n)
        m_cyc |-> (beat_cnt < 3'd4))
        else begin
            bus_errs++;
            $display("more than four beats in one refill cycle");
        end

    a_beat_count: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(m_cyc) |-> (beat_cnt == 3'd4))
        else begin
            bus_errs++;
            $display("refill cycle ended after %0d beats instead of four",
                $sampled(beat_cnt));
        end

    // one core request, held until the edge that samples ack or err
    task automatic bus_request(input addr_t a, input logic write, input logic want_hit,
            input logic want_refill);
        cyc = 1'b1;
        stb = 1'b1;
        we = write;
        adr = a;
        expect_hit = want_hit;
        expect_refill = want_refill;
        do begin
            @(posedge clk);
            #1;
        end while (!(ack || err));
        @(posedge clk);
        #1;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        expect_hit = 1'b0;
        expect_refill = 1'b0;
        // idle cycle so the next request starts with a rising stb
        @(posedge clk);
        #1;
    endtask

    initial begin
        rst_n = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        expect_hit = 1'b0;
        expect_refill = 1'b0;
        seed_val = $urandom(32'h898e7ff0);
        set_a = set_idx_t'($urandom);
        tag_a = tag_t'($urandom);
        tag_b = tag_a ^ tag_t'(1);
        tag_c = tag_a ^ tag_t'(2);
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        // first read after reset, then the same line again
        bus_request(word_adr(tag_a, set_a, 2'd0), 1'b0, 1'b0, 1'b1);
        bus_request(word_adr(tag_a, set_a, 2'd0), 1'b0, 1'b1, 1'b0);
        bus_request(word_adr(tag_a, set_a, 2'd3), 1'b0, 1'b1, 1'b0);
        bus_request(word_adr(tag_a, set_a, 2'd1), 1'b1, 1'b0, 1'b0);
        // second tag fills the other way, then A B A B all hit
        bus_request(word_adr(tag_b, set_a, 2'd1), 1'b0, 1'b0, 1'b1);
        bus_request(word_adr(tag_a, set_a, 2'd2), 1'b0, 1'b1, 1'b0);
        bus_request(word_adr(tag_b, set_a, 2'd1), 1'b0, 1'b1, 1'b0);
        bus_request(word_adr(tag_a, set_a, 2'd0), 1'b0, 1'b1, 1'b0);
        bus_request(word_adr(tag_b, set_a, 2'd2), 1'b0, 1'b1, 1'b0);
        // third tag evicts one of them
        bus_request(word_adr(tag_c, set_a, 2'd0), 1'b0, 1'b0, 1'b1);
        bus_request(word_adr(tag_c, set_a, 2'd2), 1'b0, 1'b1, 1'b0);
        bus_request(word_adr(tag_a, set_a, 2'd1), 1'b0, 1'b0, 1'b0);
        bus_request(word_adr(tag_b, set_a, 2'd3), 1'b0, 1'b0, 1'b0);
        // four tags over two sets keep evicting
        for (int i = 0; i < n_random; i++) begin
            r_set = set_a + set_idx_t'($urandom % 2);
            r_tag = tag_a ^ tag_t'($urandom % 4);
            r_word = word_off_t'($urandom);
            r_write = (($urandom % 8) == 0);
            bus_request(word_adr(r_tag, r_set, r_word), r_write, 1'b0, 1'b0);
        end
        repeat (2) @(posedge clk);
        $display("checks done: %0d data errors, %0d timing errors, %0d bus errors",
            data_errs, timing_errs, bus_errs);
        if (data_errs + timing_errs + bus_errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("checks done: %0d data errors, %0d timing errors, %0d bus errors",
                data_errs, timing_errs, bus_errs);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/icache_pkg.sv
src/way_store.sv
cache/cache_core.sv
src/fetch_port.sv
src/refill_master.sv
src/icache_top.sv
bench/mem_model.sv
bench/tb_icache.sv

// File: Bender.yml
package:
  name: icache

sources:
  - include_dirs:
      - common
    files:
      - common/icache_pkg.sv
      - src/way_store.sv
      - cache/cache_core.sv
      - src/fetch_port.sv
      - src/refill_master.sv
      - src/icache_top.sv
  - target: test
    files:
      - bench/mem_model.sv
      - bench/tb_icache.sv
